//--- Makefile
VERILATOR ?= verilator
TOP       := tb_periph_subsystem
FILELIST  := vlog.f
VFLAGS    := --binary --timing --assert --timescale 1ns/1ps -j 0
OBJ_DIR   := obj_dir
LOG       := sim.log
FAIL_MSG  := SIMULATION FAILED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

run: compile
	-./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
	  echo "simulation reported failure"; exit 1; \
	elif ! grep -q "SIMULATION PASSED" $(LOG); then \
	  echo "simulation ended without a result"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- src/data_ram.sv
`timescale 1ns/1ps

module data_ram #(
  parameter int Depth = soc_bus_pkg::RAM_WORDS
) (
  input  logic               clk_sys_in,

  input  logic               req_i,
  input  logic               we_i,
  input  soc_bus_pkg::addr_t addr_i,
  input  soc_bus_pkg::be_t   be_i,
  input  soc_bus_pkg::data_t wdata_i,

  output soc_bus_pkg::data_t rdata_o
);
  import soc_bus_pkg::*;

  localparam int IdxW = (Depth > 1) ? $clog2(Depth) : 1;

  data_t            mem [Depth];
  logic [IdxW-1:0]  word_idx;

  assign word_idx = addr_i[2 +: IdxW];  // drop the byte offset

  // byte-lane writes
  always_ff @(posedge clk_sys_in) begin
    if (req_i && we_i) begin
      for (int lane = 0; lane < 4; lane++) begin
        if (be_i[lane]) begin
          mem[word_idx][8*lane +: 8] <= wdata_i[8*lane +: 8];
        end
      end
    end
  end

  // registered read port, writes answer with zero
  always_ff @(posedge clk_sys_in) begin
    if (req_i) begin
      rdata_o <= we_i ? '0 : mem[word_idx];
    end
  end

endmodule

//--- src/gpio_regs.sv
`timescale 1ns/1ps

module gpio_regs (
  input  logic               clk_sys_in,
  input  logic               rst_sys_in,

  input  logic               req_i,
  input  logic               we_i,
  input  soc_bus_pkg::addr_t addr_i,
  input  soc_bus_pkg::data_t wdata_i,
  output soc_bus_pkg::data_t rdata_o,

  input  soc_bus_pkg::gpio_t gp_i,
  output soc_bus_pkg::gpio_t gp_o
);
  import soc_bus_pkg::*;

  gpio_t       gp_meta_q;  // first sync stage
  gpio_t       gp_in_q;    // synchronized input
  gpio_t       gp_out_q;
  logic [11:0] reg_ofs;

  assign reg_ofs = addr_i[11:0];

  always_ff @(posedge clk_sys_in or negedge rst_sys_in) begin
    if (!rst_sys_in) begin
      gp_meta_q <= '0;
      gp_in_q   <= '0;
      gp_out_q  <= '0;
    end else begin
      gp_meta_q <= gp_i;
      gp_in_q   <= gp_meta_q;
      if (req_i && we_i && reg_ofs == GPIO_OUT_OFS) begin
        gp_out_q <= wdata_i[7:0];  // low byte only
      end
    end
  end

  assign gp_o = gp_out_q;

  always_ff @(posedge clk_sys_in) begin
    if (req_i) begin
      if (we_i) rdata_o <= '0;
      else if (reg_ofs == GPIO_OUT_OFS) rdata_o <= {24'b0, gp_out_q};
      else if (reg_ofs == GPIO_IN_OFS) rdata_o <= {24'b0, gp_in_q};
      else rdata_o <= '0;  // unused offset
    end
  end

endmodule

//--- src/periph_bus_ctrl.sv
`timescale 1ns/1ps

module periph_bus_ctrl (
  input  logic               clk_sys_in,
  input  logic               rst_sys_in,

  input  logic               req_i,
  input  soc_bus_pkg::addr_t addr_i,

  output logic               ram_req_o,
  output logic               gpio_req_o,
  output logic               timer_req_o,

  input  soc_bus_pkg::data_t ram_rdata_i,
  input  soc_bus_pkg::data_t gpio_rdata_i,
  input  soc_bus_pkg::data_t timer_rdata_i,

  output logic               rvalid_o,
  output logic               err_o,
  output soc_bus_pkg::data_t rdata_o
);
  import soc_bus_pkg::*;

  dev_e dev_sel;        // decoded target of this cycle's request
  dev_e rsp_dev_q;      // target of the request being answered
  logic rsp_pending_q;  // a response is due this cycle

  //////////////////////////////////////////////////////////////////////
  // request phase
  //////////////////////////////////////////////////////////////////////

  // full range check on every region, lower and upper bound
  always_comb begin
    if (addr_i >= RAM_START && addr_i < RAM_START + RAM_SIZE) begin
      dev_sel = DEV_RAM;
    end else if (addr_i >= GPIO_START && addr_i < GPIO_START + GPIO_SIZE) begin
      dev_sel = DEV_GPIO;
    end else if (addr_i >= TIMER_START && addr_i < TIMER_START + TIMER_SIZE) begin
      dev_sel = DEV_TIMER;
    end else begin
      dev_sel = DEV_NONE;  // hole in the map
    end
  end

  // unmapped requests never reach a device
  assign ram_req_o   = req_i && (dev_sel == DEV_RAM);
  assign gpio_req_o  = req_i && (dev_sel == DEV_GPIO);
  assign timer_req_o = req_i && (dev_sel == DEV_TIMER);

  //////////////////////////////////////////////////////////////////////
  // response phase
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_sys_in or negedge rst_sys_in) begin
    if (!rst_sys_in) begin
      rsp_pending_q <= 1'b0;
      rsp_dev_q     <= DEV_NONE;
    end else begin
      rsp_pending_q <= req_i;  // every request answered next cycle
      if (req_i) begin
        rsp_dev_q <= dev_sel;
      end
    end
  end

  assign rvalid_o = rsp_pending_q;
  assign err_o    = rsp_pending_q && (rsp_dev_q == DEV_NONE);

  // pick the device that registered its data last cycle
  always_comb begin
    rdata_o = '0;
    if (rsp_pending_q) begin
      case (rsp_dev_q)
        DEV_RAM:   rdata_o = ram_rdata_i;
        DEV_GPIO:  rdata_o = gpio_rdata_i;
        DEV_TIMER: rdata_o = timer_rdata_i;
        default:   rdata_o = '0;  // error response
      endcase
    end
  end

endmodule

//--- src/periph_subsystem_top.sv
`timescale 1ns/1ps

module periph_subsystem_top (
  input  logic               clk_sys_in,
  input  logic               rst_sys_in,

  input  logic               req_i,
  input  logic               we_i,
  input  soc_bus_pkg::addr_t addr_i,
  input  soc_bus_pkg::be_t   be_i,
  input  soc_bus_pkg::data_t wdata_i,
  output logic               rvalid_o,
  output logic               err_o,
  output soc_bus_pkg::data_t rdata_o,

  input  soc_bus_pkg::gpio_t gp_i,
  output soc_bus_pkg::gpio_t gp_o,
  output logic               timer_irq_o
);
  import soc_bus_pkg::*;

  logic  ram_req, gpio_req, timer_req;             // per-device strobes
  data_t ram_rdata, gpio_rdata, timer_rdata;       // registered device data

  periph_bus_ctrl u_bus_ctrl (
    .clk_sys_in, .rst_sys_in, .req_i, .addr_i,
    .ram_req_o(ram_req), .gpio_req_o(gpio_req), .timer_req_o(timer_req),
    .ram_rdata_i(ram_rdata), .gpio_rdata_i(gpio_rdata), .timer_rdata_i(timer_rdata),
    .rvalid_o, .err_o, .rdata_o
  );

  data_ram u_data_ram (
    .clk_sys_in, .req_i(ram_req), .we_i, .addr_i, .be_i, .wdata_i,
    .rdata_o(ram_rdata)
  );

  gpio_regs u_gpio (
    .clk_sys_in, .rst_sys_in, .req_i(gpio_req), .we_i, .addr_i, .wdata_i,
    .rdata_o(gpio_rdata), .gp_i, .gp_o
  );

  timer_regs u_timer (
    .clk_sys_in, .rst_sys_in, .req_i(timer_req), .we_i, .addr_i, .wdata_i,
    .rdata_o(timer_rdata), .timer_irq_o
  );

endmodule

//--- src/soc_bus_pkg.sv
package soc_bus_pkg;

  //////////////////////////////////////////////////////////////////////
  // bus types
  //////////////////////////////////////////////////////////////////////

  typedef logic [31:0] addr_t;   // byte address on the host port
  typedef logic [31:0] data_t;   // bus word
  typedef logic [3:0]  be_t;     // one bit per byte lane
  typedef logic [7:0]  gpio_t;   // gpio pin vector

  // device targeted by the current request
  typedef enum logic [1:0] {
    DEV_RAM,
    DEV_GPIO,
    DEV_TIMER,
    DEV_NONE                     // address not in the map
  } dev_e;

  //////////////////////////////////////////////////////////////////////
  // address map
  //////////////////////////////////////////////////////////////////////

  localparam addr_t RAM_START   = 32'h0020_0000;
  localparam addr_t RAM_SIZE    = 32'h0000_1000;  // 4 KiB
  localparam int    RAM_WORDS   = RAM_SIZE / 4;

  localparam addr_t GPIO_START  = 32'h8000_0000;
  localparam addr_t GPIO_SIZE   = 32'h0000_1000;  // 4 KiB

  localparam addr_t TIMER_START = 32'h8000_2000;
  localparam addr_t TIMER_SIZE  = 32'h0000_1000;  // 4 KiB

  // register offsets within a 4 KiB device window
  localparam logic [11:0] GPIO_OUT_OFS    = 12'h000;
  localparam logic [11:0] GPIO_IN_OFS     = 12'h004;

  localparam logic [11:0] TIMER_COUNT_OFS = 12'h000;
  localparam logic [11:0] TIMER_CMP_OFS   = 12'h004;
  localparam logic [11:0] TIMER_CTRL_OFS  = 12'h008;  // bit 0 is enable

endpackage

//--- src/timer_regs.sv
`timescale 1ns/1ps

module timer_regs (
  input  logic               clk_sys_in,
  input  logic               rst_sys_in,

  input  logic               req_i,
  input  logic               we_i,
  input  soc_bus_pkg::addr_t addr_i,
  input  soc_bus_pkg::data_t wdata_i,
  output soc_bus_pkg::data_t rdata_o,

  output logic               timer_irq_o
);
  import soc_bus_pkg::*;

  data_t       count_q;
  data_t       cmp_q;
  logic        en_q;
  logic        irq_q;
  logic [11:0] reg_ofs;
  logic        wr_count;
  logic        wr_cmp;
  logic        wr_ctrl;

  assign reg_ofs  = addr_i[11:0];
  assign wr_count = req_i && we_i && (reg_ofs == TIMER_COUNT_OFS);
  assign wr_cmp   = req_i && we_i && (reg_ofs == TIMER_CMP_OFS);
  assign wr_ctrl  = req_i && we_i && (reg_ofs == TIMER_CTRL_OFS);

  //////////////////////////////////////////////////////////////////////
  // counter, compare and control
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_sys_in or negedge rst_sys_in) begin
    if (!rst_sys_in) begin
      count_q <= '0;
      cmp_q   <= '1;    // no match until programmed
      en_q    <= 1'b0;
      irq_q   <= 1'b0;
    end else begin
      if (wr_ctrl) begin
        en_q <= wdata_i[0];
      end
      // bus write wins over the increment
      if (wr_count) begin
        count_q <= wdata_i;
      end else if (en_q) begin
        count_q <= count_q + 32'd1;
      end
      if (wr_cmp) begin
        cmp_q <= wdata_i;
      end
      irq_q <= en_q && (count_q >= cmp_q);  // level, not a pulse
    end
  end

  assign timer_irq_o = irq_q;

  // register read, zero on writes and unused offsets
  always_ff @(posedge clk_sys_in) begin
    if (req_i) begin
      if (we_i) rdata_o <= '0;
      else if (reg_ofs == TIMER_COUNT_OFS) rdata_o <= count_q;
      else if (reg_ofs == TIMER_CMP_OFS) rdata_o <= cmp_q;
      else if (reg_ofs == TIMER_CTRL_OFS) rdata_o <= {31'b0, en_q};
      else rdata_o <= '0;
    end
  end

endmodule

//--- tb/stim_bus.txt
# W/R/B addr be wdata exp_rdata exp_err (B = back-to-back read)
# G gp_i, O exp gp_o, N idle cycle, I wait irq high, Q irq low
Q
W 00200000 f 11223344 0 0
W 00200ffc f a5a5a5a5 0 0
W 00200100 f deadbeef 0 0
R 00200000 0 0 11223344 0
R 00200ffc 0 0 a5a5a5a5 0
R 00200100 0 0 deadbeef 0
W 00200100 5 00cc00aa 0 0
R 00200100 0 0 deccbeaa 0
W 80000000 f 0000015a 0 0
O 5a
R 80000000 0 0 0000005a 0
G c3
N
N
N
R 80000004 0 0 000000c3 0
W 00001000 f 12345678 0 1
R 00001000 0 0 0 1
W 00201000 f 12345678 0 1
R 00201000 0 0 0 1
R 00200000 0 0 11223344 0
R 00200ffc 0 0 a5a5a5a5 0
W 80002004 f 00000040 0 0
W 80002000 f 00000000 0 0
W 80002008 f 00000001 0 0
I
W 80002004 f ffffffff 0 0
N
Q
R 80002004 0 0 ffffffff 0
B 00200000 0 0 11223344 0
B 80000004 0 0 000000c3 0
B 00001000 0 0 0 1
B 00200ffc 0 0 a5a5a5a5 0
R 80002008 0 0 00000001 0

//--- tb/tb_periph_subsystem.sv
`timescale 1ns/1ps

module tb_periph_subsystem;
  import soc_bus_pkg::*;

  localparam int    RSP_TIMEOUT = 20;    // cycles to wait for rvalid_o
  localparam int    IRQ_TIMEOUT = 200;   // counter needs ~0x40 cycles to match
  localparam string STIM_FILE   = "tb/stim_bus.txt";

  logic  clk_sys_in = 1'b0;
  logic  rst_sys_in;
  logic  req_i;
  logic  we_i;
  addr_t addr_i;
  be_t   be_i;
  data_t wdata_i;
  gpio_t gp_i;
  logic  rvalid_o;
  logic  err_o;
  logic  timer_irq_o;
  data_t rdata_o;
  gpio_t gp_o;

  // reads queued for a back-to-back burst
  addr_t burst_addr[$];
  data_t burst_rdata[$];
  logic  burst_err[$];

  periph_subsystem_top u_dut (
    .clk_sys_in, .rst_sys_in, .req_i, .we_i, .addr_i, .be_i, .wdata_i,
    .rvalid_o, .err_o, .rdata_o, .gp_i, .gp_o, .timer_irq_o
  );

  always #5 clk_sys_in = ~clk_sys_in;  // 100 MHz

  //////////////////////////////////////////////////////////////////////
  // helpers
  //////////////////////////////////////////////////////////////////////

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("SIMULATION FAILED");
    $fatal(1);
  endtask

  task automatic check_response(input string tag, input data_t exp_rdata, input logic exp_err);
    assert (rdata_o === exp_rdata)
      else abort_run($sformatf("** Error %s: rdata_o expected %h, got %h",
                               tag, exp_rdata, rdata_o));
    assert (err_o === exp_err)
      else abort_run($sformatf("** Error %s: err_o expected %h, got %h",
                               tag, exp_err, err_o));
  endtask

  // returns at the negedge of the response to the request on the bus
  task automatic wait_response();
    int cycles;
    cycles = 0;
    do begin
      @(posedge clk_sys_in);
      req_i <= 1'b0;
      @(negedge clk_sys_in);
      cycles++;
      if (!rvalid_o && cycles >= RSP_TIMEOUT) begin
        abort_run("timed out waiting for rvalid_o after a bus request");
      end
    end while (!rvalid_o);
    assert (cycles == 1)
      else abort_run($sformatf("** Error rvalid_o latency: expected %h, got %h",
                               1, cycles));
  endtask

  task automatic bus_access(input logic write, input addr_t addr, input be_t be,
                            input data_t wdata, input data_t exp_rdata, input logic exp_err);
    @(posedge clk_sys_in);
    req_i   <= 1'b1;
    we_i    <= write;
    addr_i  <= addr;
    be_i    <= be;
    wdata_i <= wdata;
    wait_response();
    check_response($sformatf("%s at %h", write ? "write" : "read", addr), exp_rdata, exp_err);
  endtask

  // one read per cycle with responses checked in issue order
  task automatic run_burst();
    int   n_sent;
    int   n_got;
    int   cycles;
    logic issued;
    logic issued_prev;  // a read went out on the previous edge
    n_sent      = 0;
    n_got       = 0;
    cycles      = 0;
    issued_prev = 1'b0;
    while (n_got < burst_addr.size()) begin
      @(posedge clk_sys_in);
      issued = (n_sent < burst_addr.size());
      if (issued) begin
        req_i   <= 1'b1;
        we_i    <= 1'b0;
        addr_i  <= burst_addr[n_sent];
        be_i    <= '0;
        wdata_i <= '0;
        n_sent++;
      end else begin
        req_i <= 1'b0;
      end
      @(negedge clk_sys_in);
      assert (rvalid_o === issued_prev)
        else abort_run($sformatf("** Error burst rvalid_o: expected %h, got %h",
                                 issued_prev, rvalid_o));
      if (rvalid_o) begin
        check_response($sformatf("burst read %0d at %h", n_got, burst_addr[n_got]),
                       burst_rdata[n_got], burst_err[n_got]);
        n_got++;
      end
      issued_prev = issued;
      cycles++;
      if (n_got < burst_addr.size() && cycles >= burst_addr.size() + RSP_TIMEOUT) begin
        abort_run("timed out waiting for rvalid_o during a back-to-back burst");
      end
    end
    burst_addr.delete();
    burst_rdata.delete();
    burst_err.delete();
  endtask

  task automatic wait_irq();
    int cycles;
    cycles = 0;
    while (!timer_irq_o) begin
      @(negedge clk_sys_in);
      cycles++;
      if (!timer_irq_o && cycles >= IRQ_TIMEOUT) begin
        abort_run("timed out waiting for timer_irq_o to rise");
      end
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // stimulus
  //////////////////////////////////////////////////////////////////////

  initial begin
    int         fd;
    int         n;
    int         line_no;
    int         ops_done;
    string      line;
    logic [7:0] op;
    data_t      f1, f2, f3, f4, f5;

    rst_sys_in = 1'b0;
    req_i      = 1'b0;
    we_i       = 1'b0;
    addr_i     = '0;
    be_i       = '0;
    wdata_i    = '0;
    gp_i       = '0;
    line_no    = 0;
    ops_done   = 0;

    repeat (4) @(posedge clk_sys_in);
    rst_sys_in <= 1'b1;

    fd = $fopen(STIM_FILE, "r");
    if (fd == 0) begin
      abort_run("could not open the stimulus file tb/stim_bus.txt");
    end

    while (!$feof(fd)) begin
      line = "";
      n = $fgets(line, fd);
      line_no++;
      if (n > 0 && line.len() > 0) begin
        op = line.getc(0);
        if (op != "#" && op != "\n" && op != "\r") begin
          f1 = '0;
          f2 = '0;
          f3 = '0;
          f4 = '0;
          f5 = '0;
          n = $sscanf(line.substr(1, line.len() - 1), "%h %h %h %h %h", f1, f2, f3, f4, f5);
          if (op != "B" && burst_addr.size() > 0) run_burst();
          case (op)
            "W": bus_access(1'b1, f1, f2[3:0], f3, f4, f5[0]);
            "R": bus_access(1'b0, f1, f2[3:0], f3, f4, f5[0]);
            "B": begin
              burst_addr.push_back(f1);
              burst_rdata.push_back(f4);
              burst_err.push_back(f5[0]);
            end
            "G": begin
              @(posedge clk_sys_in);
              gp_i <= f1[7:0];
              @(negedge clk_sys_in);
            end
            "O": begin
              @(negedge clk_sys_in);
              assert (gp_o === f1[7:0])
                else abort_run($sformatf("** Error gp_o: expected %h, got %h", f1[7:0], gp_o));
            end
            "N": begin
              @(posedge clk_sys_in);
              @(negedge clk_sys_in);
            end
            "I": wait_irq();
            "Q": begin
              @(negedge clk_sys_in);
              assert (timer_irq_o === 1'b0)
                else abort_run($sformatf("** Error timer_irq_o: expected %h, got %h",
                                         1'b0, timer_irq_o));
            end
            default: abort_run($sformatf("unknown operation on line %0d of the stimulus file",
                                         line_no));
          endcase
          ops_done++;
        end
      end
    end
    if (burst_addr.size() > 0) run_burst();  // burst at end of file
    $fclose(fd);

    if (ops_done == 0) begin
      abort_run("the stimulus file held no operations");
    end else begin
      $display("SIMULATION PASSED");
      $finish;
    end
  end

endmodule

//--- vlog.f
src/soc_bus_pkg.sv
src/periph_bus_ctrl.sv
src/data_ram.sv
src/gpio_regs.sv
src/timer_regs.sv
src/periph_subsystem_top.sv
tb/tb_periph_subsystem.sv
